// File: design/cl_scrub_pkg.sv
/* Shared widths, burst constants and scrubber states for the DRAM scrub shell.
   Imported by every design unit that needs one of these definitions. */
`default_nettype none

package cl_scrub_pkg;

   // DDR write channel fields
   typedef logic [63:0]  ddr_addr_t;
   typedef logic [511:0] ddr_data_t;
   typedef logic [63:0]  ddr_strb_t;
   typedef logic [15:0]  ddr_id_t;

   // Same width as the AXI length field
   typedef logic [7:0]   beat_cnt_t;

   // DDR controller status port
   typedef logic [7:0]   stat_addr_t;
   typedef logic [31:0]  stat_data_t;
   typedef logic [7:0]   stat_int_t;

   localparam int      BEAT_BYTES = 64;
   localparam ddr_id_t SCRB_ID    = '0;

   typedef enum logic [2:0] {
      S_IDLE,
      S_ADDR,
      S_DATA,
      S_RESP,
      S_DONE
   } scrub_state_t;

endpackage

`default_nettype wire

// File: design/scrub_ctl_if.sv
/* Control bundle between the scrub sequencer, the address counter and the write port */
`default_nettype none

interface scrub_ctl_if (input logic clk);
   import cl_scrub_pkg::*;

   // Sequencer requests
   logic      start;
   logic      issue_aw;
   logic      send_w;

   // Handshake completions from the write port
   logic      aw_done;
   logic      w_beat;
   logic      b_done;

   // Position within the region
   ddr_addr_t addr;
   beat_cnt_t beat;
   logic      last_beat;
   logic      last_burst;

   modport fsm (input clk, output start, issue_aw, send_w,
                input aw_done, w_beat, b_done, last_beat, last_burst);
   modport cnt (input clk, start, w_beat, b_done,
                output addr, beat, last_beat, last_burst);
   modport port (input clk, issue_aw, send_w, addr, last_beat,
                 output aw_done, w_beat, b_done);

endinterface

`default_nettype wire

// File: design/scrub_fsm.sv
/* Scrub sequencer: walks each burst through address, data and response phases
   and holds the done state until the next reset. */
`default_nettype none

module scrub_fsm (
   input  logic         clk,
   input  logic         pipe_rst_n,
   input  logic         scrb_en,
   output logic         scrb_done,
   scrub_ctl_if.fsm     ctl
);
   import cl_scrub_pkg::*;

   scrub_state_t state;
   scrub_state_t state_nxt;

   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
         state <= S_IDLE;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         S_IDLE:
            if (scrb_en)
               state_nxt = S_ADDR;
         S_ADDR:
            if (ctl.aw_done)
               state_nxt = S_DATA;
         // Leave once the beat flagged as last has been accepted
         S_DATA:
            if (ctl.w_beat && ctl.last_beat)
               state_nxt = S_RESP;
         S_RESP:
         begin
            if (ctl.b_done)
               state_nxt = ctl.last_burst ? S_DONE : S_ADDR;
         end
         S_DONE:
            state_nxt = S_DONE;
         default:
            state_nxt = S_IDLE;
      endcase
   end

   // Counter restarts on the way out of idle
   assign ctl.start    = (state == S_IDLE) && scrb_en;
   assign ctl.issue_aw = (state == S_ADDR);
   assign ctl.send_w   = (state == S_DATA);

   assign scrb_done = (state == S_DONE);

endmodule

`default_nettype wire

// File: design/scrub_addr_counter.sv
/* Tracks the current burst address and the beat within it, and flags the last
   beat of a burst and the last burst of the region. */
`default_nettype none

module scrub_addr_counter #(
   parameter cl_scrub_pkg::ddr_addr_t SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int                      SCRB_BURST_LEN_MINUS1 = 15
) (
   input  logic         clk,
   input  logic         pipe_rst_n,
   scrub_ctl_if.cnt     ctl
);
   import cl_scrub_pkg::*;

   localparam ddr_addr_t BURST_BYTES = ddr_addr_t'((SCRB_BURST_LEN_MINUS1 + 1) * BEAT_BYTES);

   ddr_addr_t next_addr;

   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n || ctl.start)
      begin
         ctl.addr <= '0;
         ctl.beat <= '0;
      end
      else if (ctl.b_done)
      begin
         ctl.addr <= next_addr;
         ctl.beat <= '0;
      end
      else if (ctl.w_beat)
         ctl.beat <= ctl.beat + 1'b1;
   end

   assign next_addr = ctl.addr + BURST_BYTES;

   assign ctl.last_beat  = (ctl.beat == beat_cnt_t'(SCRB_BURST_LEN_MINUS1));
   // Next burst would start beyond the region
   assign ctl.last_burst = (next_addr > SCRB_MAX_ADDR);

endmodule

`default_nettype wire

// File: design/scrub_wr_port.sv
/* DDR write channel driver for the scrubber: zero data, full strobes, valid
   held under back-pressure, and a sticky error on a bad write response. */
`default_nettype none

module scrub_wr_port #(
   parameter int SCRB_BURST_LEN_MINUS1 = 15
) (
   input  logic                      clk,
   input  logic                      pipe_rst_n,
   scrub_ctl_if.port                 ctl,
   output logic                      ddr_awvalid,
   output cl_scrub_pkg::ddr_addr_t   ddr_awaddr,
   output cl_scrub_pkg::beat_cnt_t   ddr_awlen,
   input  logic                      ddr_awready,
   output logic                      ddr_wvalid,
   output cl_scrub_pkg::ddr_data_t   ddr_wdata,
   output cl_scrub_pkg::ddr_strb_t   ddr_wstrb,
   output logic                      ddr_wlast,
   input  logic                      ddr_wready,
   input  logic                      ddr_bvalid,
   input  logic [1:0]                ddr_bresp,
   output logic                      scrb_err
);
   import cl_scrub_pkg::*;

   //////////////////////////////////////////////////
   // Address and data valids
   //////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         ddr_awvalid <= 1'b0;
         ddr_wvalid  <= 1'b0;
      end
      else
      begin
         if (ctl.aw_done)
            ddr_awvalid <= 1'b0;
         else if (ctl.issue_aw)
            ddr_awvalid <= 1'b1;

         // Valid stays up across the burst, drops after the wlast beat
         if (ctl.w_beat && ddr_wlast)
            ddr_wvalid <= 1'b0;
         else if (ctl.send_w)
            ddr_wvalid <= 1'b1;
      end
   end

   // Address captured only while no request is outstanding
   always_ff @(posedge clk)
   begin
      if (ctl.issue_aw && !ddr_awvalid)
         ddr_awaddr <= ctl.addr;
   end

   assign ddr_awlen = beat_cnt_t'(SCRB_BURST_LEN_MINUS1);
   assign ddr_wdata = '0;
   assign ddr_wstrb = '1;
   assign ddr_wlast = ddr_wvalid && ctl.last_beat;

   //////////////////////////////////////////////////
   // Handshake pulses and response status
   //////////////////////////////////////////////////
   assign ctl.aw_done = ddr_awvalid && ddr_awready;
   assign ctl.w_beat  = ddr_wvalid && ddr_wready;
   assign ctl.b_done  = ddr_bvalid;

   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
         scrb_err <= 1'b0;
      else if (ddr_bvalid && (ddr_bresp != 2'b00))
         scrb_err <= 1'b1;
   end

endmodule

`default_nettype wire

// File: design/ddr_stat_pipe.sv
/* Retiming stages on the DDR controller status port, one chain per direction.
   Each chain delays its inputs by exactly STAT_STAGES clocks. */
`default_nettype none

module ddr_stat_pipe #(
   parameter int STAT_STAGES = 8
) (
   input  logic                     clk,
   input  logic                     pipe_rst_n,
   input  logic                     req_wr,
   input  logic                     req_rd,
   input  cl_scrub_pkg::stat_addr_t req_addr,
   input  cl_scrub_pkg::stat_data_t req_wdata,
   output logic                     fwd_wr,
   output logic                     fwd_rd,
   output cl_scrub_pkg::stat_addr_t fwd_addr,
   output cl_scrub_pkg::stat_data_t fwd_wdata,
   input  logic                     rsp_ack,
   input  cl_scrub_pkg::stat_data_t rsp_rdata,
   input  cl_scrub_pkg::stat_int_t  rsp_int,
   output logic                     ret_ack,
   output cl_scrub_pkg::stat_data_t ret_rdata,
   output cl_scrub_pkg::stat_int_t  ret_int
);
   import cl_scrub_pkg::*;

   logic [STAT_STAGES-1:0] wr_sr;
   logic [STAT_STAGES-1:0] rd_sr;
   logic [STAT_STAGES-1:0] ack_sr;
   stat_addr_t             addr_sr  [STAT_STAGES];
   stat_data_t             wdata_sr [STAT_STAGES];
   stat_data_t             rdata_sr [STAT_STAGES];
   stat_int_t              int_sr   [STAT_STAGES];

   //////////////////////////////////////////////////
   // Strobes, cleared by reset
   //////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         wr_sr  <= '0;
         rd_sr  <= '0;
         ack_sr <= '0;
      end
      else
      begin
         wr_sr[0]  <= req_wr;
         rd_sr[0]  <= req_rd;
         ack_sr[0] <= rsp_ack;
         for (int i = 1; i < STAT_STAGES; i++)
         begin
            wr_sr[i]  <= wr_sr[i-1];
            rd_sr[i]  <= rd_sr[i-1];
            ack_sr[i] <= ack_sr[i-1];
         end
      end
   end

   // Payload follows its strobe
   always_ff @(posedge clk)
   begin
      addr_sr[0]  <= req_addr;
      wdata_sr[0] <= req_wdata;
      rdata_sr[0] <= rsp_rdata;
      int_sr[0]   <= rsp_int;
      for (int i = 1; i < STAT_STAGES; i++)
      begin
         addr_sr[i]  <= addr_sr[i-1];
         wdata_sr[i] <= wdata_sr[i-1];
         rdata_sr[i] <= rdata_sr[i-1];
         int_sr[i]   <= int_sr[i-1];
      end
   end

   assign fwd_wr    = wr_sr[STAT_STAGES-1];
   assign fwd_rd    = rd_sr[STAT_STAGES-1];
   assign fwd_addr  = addr_sr[STAT_STAGES-1];
   assign fwd_wdata = wdata_sr[STAT_STAGES-1];
   assign ret_ack   = ack_sr[STAT_STAGES-1];
   assign ret_rdata = rdata_sr[STAT_STAGES-1];
   assign ret_int   = int_sr[STAT_STAGES-1];

endmodule

`default_nettype wire

// File: design/cl_dram_scrub.sv
/* Memory-side housekeeping of the accelerator shell: DDR region scrub after
   reset, status port retiming and the FLR done response. */
`default_nettype none

module cl_dram_scrub #(
   parameter cl_scrub_pkg::ddr_addr_t SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int                      SCRB_BURST_LEN_MINUS1 = 15,
   parameter int                      STAT_STAGES           = 8
) (
   input  logic                     clk_main_a0,
   input  logic                     pipe_rst_n,

   input  logic                     sh_cl_flr_assert,
   output logic                     cl_sh_flr_done,

   input  logic                     scrb_en,
   output logic                     scrb_done,
   output logic                     scrb_err,

   output logic                     ddr_awvalid,
   output cl_scrub_pkg::ddr_addr_t  ddr_awaddr,
   output cl_scrub_pkg::ddr_id_t    ddr_awid,
   output cl_scrub_pkg::beat_cnt_t  ddr_awlen,
   input  logic                     ddr_awready,
   output logic                     ddr_wvalid,
   output cl_scrub_pkg::ddr_data_t  ddr_wdata,
   output cl_scrub_pkg::ddr_strb_t  ddr_wstrb,
   output logic                     ddr_wlast,
   input  logic                     ddr_wready,
   input  logic                     ddr_bvalid,
   input  logic [1:0]               ddr_bresp,
   output logic                     ddr_bready,

   input  logic                     sh_ddr_stat_wr,
   input  logic                     sh_ddr_stat_rd,
   input  cl_scrub_pkg::stat_addr_t sh_ddr_stat_addr,
   input  cl_scrub_pkg::stat_data_t sh_ddr_stat_wdata,
   output logic                     stat_wr_q,
   output logic                     stat_rd_q,
   output cl_scrub_pkg::stat_addr_t stat_addr_q,
   output cl_scrub_pkg::stat_data_t stat_wdata_q,

   input  logic                     stat_ack_q,
   input  cl_scrub_pkg::stat_data_t stat_rdata_q,
   input  cl_scrub_pkg::stat_int_t  stat_int_q,
   output logic                     ddr_sh_stat_ack,
   output cl_scrub_pkg::stat_data_t ddr_sh_stat_rdata,
   output cl_scrub_pkg::stat_int_t  ddr_sh_stat_int
);
   import cl_scrub_pkg::*;

   logic sh_cl_flr_assert_q;

   // FLR answered with a single-cycle done, even while the request stays high
   always_ff @(posedge clk_main_a0)
   begin
      if (!pipe_rst_n)
      begin
         sh_cl_flr_assert_q <= 1'b0;
         cl_sh_flr_done     <= 1'b0;
      end
      else
      begin
         sh_cl_flr_assert_q <= sh_cl_flr_assert;
         cl_sh_flr_done     <= sh_cl_flr_assert_q && !cl_sh_flr_done;
      end
   end

   //////////////////////////////////////////////////
   // DDR scrubber
   //////////////////////////////////////////////////
   assign ddr_awid   = SCRB_ID;
   assign ddr_bready = 1'b1;

   scrub_ctl_if u_ctl_if (.clk(clk_main_a0));

   scrub_fsm u_fsm (
      .clk        (clk_main_a0),
      .pipe_rst_n (pipe_rst_n),
      .scrb_en    (scrb_en),
      .scrb_done  (scrb_done),
      .ctl        (u_ctl_if.fsm)
   );

   scrub_addr_counter #(
      .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
      .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
   ) u_addr_counter (
      .clk        (clk_main_a0),
      .pipe_rst_n (pipe_rst_n),
      .ctl        (u_ctl_if.cnt)
   );

   scrub_wr_port #(
      .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
   ) u_wr_port (
      .clk         (clk_main_a0),
      .pipe_rst_n  (pipe_rst_n),
      .ctl         (u_ctl_if.port),
      .ddr_awvalid (ddr_awvalid),
      .ddr_awaddr  (ddr_awaddr),
      .ddr_awlen   (ddr_awlen),
      .ddr_awready (ddr_awready),
      .ddr_wvalid  (ddr_wvalid),
      .ddr_wdata   (ddr_wdata),
      .ddr_wstrb   (ddr_wstrb),
      .ddr_wlast   (ddr_wlast),
      .ddr_wready  (ddr_wready),
      .ddr_bvalid  (ddr_bvalid),
      .ddr_bresp   (ddr_bresp),
      .scrb_err    (scrb_err)
   );

   //////////////////////////////////////////////////
   // Status port retiming
   //////////////////////////////////////////////////
   ddr_stat_pipe #(
      .STAT_STAGES (STAT_STAGES)
   ) u_stat_pipe (
      .clk        (clk_main_a0),
      .pipe_rst_n (pipe_rst_n),
      .req_wr     (sh_ddr_stat_wr),
      .req_rd     (sh_ddr_stat_rd),
      .req_addr   (sh_ddr_stat_addr),
      .req_wdata  (sh_ddr_stat_wdata),
      .fwd_wr     (stat_wr_q),
      .fwd_rd     (stat_rd_q),
      .fwd_addr   (stat_addr_q),
      .fwd_wdata  (stat_wdata_q),
      .rsp_ack    (stat_ack_q),
      .rsp_rdata  (stat_rdata_q),
      .rsp_int    (stat_int_q),
      .ret_ack    (ddr_sh_stat_ack),
      .ret_rdata  (ddr_sh_stat_rdata),
      .ret_int    (ddr_sh_stat_int)
   );

endmodule

`default_nettype wire

// File: tests/cl_dram_scrub_sva.sv
/* Bound checks on the scrub write channel and the done flag of the DRAM scrub shell */
`default_nettype none

module cl_dram_scrub_sva (
   input logic                    clk,
   input logic                    pipe_rst_n,
   input logic                    ddr_awvalid,
   input logic                    ddr_awready,
   input cl_scrub_pkg::ddr_addr_t ddr_awaddr,
   input logic                    ddr_wvalid,
   input logic                    ddr_wready,
   input logic                    ddr_wlast,
   input logic                    scrb_done
);
   // Sticky flags, one per property
   logic aw_fail = 1'b0;
   logic w_fail = 1'b0;
   logic done_fail = 1'b0;

   a_aw_hold: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      ddr_awvalid && !ddr_awready |=> ddr_awvalid && $stable(ddr_awaddr))
   else
   begin
      $error("AW valid or address changed while awready was low");
      aw_fail = 1'b1;
   end

   a_w_hold: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      ddr_wvalid && !ddr_wready |=> ddr_wvalid && $stable(ddr_wlast))
   else
   begin
      $error("W valid or wlast changed while wready was low");
      w_fail = 1'b1;
   end

   // Region is finished, the write channel must stay quiet
   a_quiet_after_done: assert property (@(posedge clk) disable iff (!pipe_rst_n)
      scrb_done |-> !ddr_awvalid && !ddr_wvalid)
   else
   begin
      $error("Write valid seen after scrub done");
      done_fail = 1'b1;
   end

endmodule

bind cl_dram_scrub cl_dram_scrub_sva u_sva (
   .clk         (clk_main_a0),
   .pipe_rst_n  (pipe_rst_n),
   .ddr_awvalid (ddr_awvalid),
   .ddr_awready (ddr_awready),
   .ddr_awaddr  (ddr_awaddr),
   .ddr_wvalid  (ddr_wvalid),
   .ddr_wready  (ddr_wready),
   .ddr_wlast   (ddr_wlast),
   .scrb_done   (scrb_done)
);

`default_nettype wire

// File: tests/tb_cl_dram_scrub.sv
/* Testbench for the DRAM scrub shell: status pipeline, scrub writes and FLR response.
   Stimulus comes from tests/scrub_patterns.txt, DDR ready stalls from an xorshift. */
`default_nettype none

module tb_cl_dram_scrub;
   import cl_scrub_pkg::*;

   localparam int STAT_STAGES = 8;
   localparam int MAX_ROWS    = 32;

   typedef struct packed {
      int         due;
      logic       wr;
      logic       rd;
      stat_addr_t addr;
      stat_data_t data;
   } req_t;

   typedef struct packed {
      int         due;
      stat_data_t rdata;
      stat_int_t  irq;
   } rsp_t;

   logic       clk;
   logic       pipe_rst_n;
   logic       sh_cl_flr_assert;
   logic       cl_sh_flr_done;
   logic       scrb_en;
   logic       scrb_done;
   logic       scrb_err;
   logic       ddr_awvalid;
   ddr_addr_t  ddr_awaddr;
   ddr_id_t    ddr_awid;
   beat_cnt_t  ddr_awlen;
   logic       ddr_awready = 1'b0;
   logic       ddr_wvalid;
   ddr_data_t  ddr_wdata;
   ddr_strb_t  ddr_wstrb;
   logic       ddr_wlast;
   logic       ddr_wready = 1'b0;
   logic       ddr_bvalid = 1'b0;
   logic [1:0] ddr_bresp = 2'b00;
   logic       ddr_bready;
   logic       sh_ddr_stat_wr;
   logic       sh_ddr_stat_rd;
   stat_addr_t sh_ddr_stat_addr;
   stat_data_t sh_ddr_stat_wdata;
   logic       stat_wr_q;
   logic       stat_rd_q;
   stat_addr_t stat_addr_q;
   stat_data_t stat_wdata_q;
   logic       stat_ack_q;
   stat_data_t stat_rdata_q;
   stat_int_t  stat_int_q;
   logic       ddr_sh_stat_ack;
   stat_data_t ddr_sh_stat_rdata;
   stat_int_t  ddr_sh_stat_int;

   // Pattern contents and scrub region
   logic [31:0] pat_mem [MAX_ROWS*5];
   logic [31:0] row_op [MAX_ROWS];
   logic [31:0] row_addr [MAX_ROWS];
   logic [31:0] row_data [MAX_ROWS];
   logic [31:0] row_int [MAX_ROWS];
   int          row_lat [MAX_ROWS];
   int          n_rows;
   longint      max_addr;
   int          len_m1 = -1;
   int          err_burst = -1;
   longint      burst_bytes;
   int          n_bursts;
   logic        cfg_ready = 1'b0;
   int          cur_lat;

   // Monitor and responder state
   int          ncyc = 0;
   req_t        req_q [$];
   rsp_t        rsp_q [$];
   int          burst_idx = 0;
   int          beat = 0;
   int          resp_count = 0;
   logic        aw_open = 1'b0;
   logic        err_exp = 1'b0;
   logic        done_seen = 1'b0;
   logic        b_pending = 1'b0;
   int          b_issued = 0;
   logic [31:0] rng = 32'h9060;

   cl_dram_scrub u_dut (.clk_main_a0(clk), .*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (act !== exp)
      begin
         $display("error %s: expected %0h, actual %0h", name, exp, act);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   //////////////////////////////////////////////////
   // Pattern file
   //////////////////////////////////////////////////
   task load_patterns;
      logic [31:0] op;
      int          i;
      logic        stop;
      $readmemh("tests/scrub_patterns.txt", pat_mem);
      i = 0;
      stop = 1'b0;
      n_rows = 0;
      while (!stop && i < MAX_ROWS)
      begin
         op = pat_mem[i*5];
         if (op == 32'hFF || $isunknown(op))
            stop = 1'b1;
         else if (op == 32'h08)
         begin
            max_addr = pat_mem[i*5+1];
            len_m1   = int'(pat_mem[i*5+2]);
         end
         else if (op == 32'h09)
            err_burst = int'(pat_mem[i*5+2]);
         else
         begin
            row_op[n_rows]   = op;
            row_addr[n_rows] = pat_mem[i*5+1];
            row_data[n_rows] = pat_mem[i*5+2];
            row_int[n_rows]  = pat_mem[i*5+3];
            row_lat[n_rows]  = int'(pat_mem[i*5+4]);
            n_rows++;
         end
         i++;
      end
      if (len_m1 < 0)
         abort_run("pattern file holds no scrub region row");
      burst_bytes = longint'(len_m1 + 1) * BEAT_BYTES;
      // One burst per step until the next start would pass the region end
      n_bursts = int'(max_addr / burst_bytes) + 1;
   endtask

   task drive_stat_row(input int i);
      @(posedge clk);
      sh_ddr_stat_wr    <= row_op[i][0];
      sh_ddr_stat_rd    <= row_op[i][1];
      sh_ddr_stat_addr  <= row_addr[i][7:0];
      sh_ddr_stat_wdata <= row_data[i];
      stat_ack_q        <= row_op[i][2];
      stat_rdata_q      <= row_data[i];
      stat_int_q        <= row_int[i][7:0];
      cur_lat           <= row_lat[i];
   endtask

   //////////////////////////////////////////////////
   // Monitors, sampled at the falling edge
   //////////////////////////////////////////////////
   task watch_stat;
      req_t r;
      rsp_t p;
      if (sh_ddr_stat_wr || sh_ddr_stat_rd)
      begin
         r.due  = ncyc + cur_lat;
         r.wr   = sh_ddr_stat_wr;
         r.rd   = sh_ddr_stat_rd;
         r.addr = sh_ddr_stat_addr;
         r.data = sh_ddr_stat_wdata;
         req_q.push_back(r);
      end
      if (stat_ack_q)
      begin
         p.due   = ncyc + cur_lat;
         p.rdata = stat_rdata_q;
         p.irq   = stat_int_q;
         rsp_q.push_back(p);
      end
      if (req_q.size() > 0 && req_q[0].due == ncyc)
      begin
         r = req_q.pop_front();
         check_val("stat request wr", r.wr, stat_wr_q);
         check_val("stat request rd", r.rd, stat_rd_q);
         check_val("stat request addr", r.addr, stat_addr_q);
         check_val("stat request wdata", r.data, stat_wdata_q);
      end
      else
         check_val("stat request idle", 0, {stat_wr_q, stat_rd_q});
      if (rsp_q.size() > 0 && rsp_q[0].due == ncyc)
      begin
         p = rsp_q.pop_front();
         check_val("stat response ack", 1, ddr_sh_stat_ack);
         check_val("stat response rdata", p.rdata, ddr_sh_stat_rdata);
         check_val("stat response int", p.irq, ddr_sh_stat_int);
      end
      else
         check_val("stat response idle", 0, ddr_sh_stat_ack);
   endtask

   task watch_scrub;
      longint exp_addr;
      check_val("scrub err", err_exp, scrb_err);
      if (done_seen)
         check_val("scrub done held", 1, scrb_done);
      if (scrb_done)
      begin
         check_val("scrub done after last response", n_bursts, resp_count);
         check_val("scrub writes after done", 0, {ddr_awvalid, ddr_wvalid});
         done_seen = 1'b1;
      end
      if (ddr_awvalid && ddr_awready)
      begin
         exp_addr = burst_idx * burst_bytes;
         check_val("scrub aw during open burst", 0, aw_open);
         check_val("scrub burst within region", 1, burst_idx < n_bursts);
         check_val("scrub awaddr", exp_addr, ddr_awaddr);
         check_val("scrub awlen", len_m1, ddr_awlen);
         check_val("scrub awid", 0, ddr_awid);
         aw_open = 1'b1;
      end
      if (ddr_wvalid && ddr_wready)
      begin
         check_val("scrub beat before aw", 1, aw_open);
         check_val("scrub wdata", 0, |ddr_wdata);
         check_val("scrub wstrb", 64'hFFFF_FFFF_FFFF_FFFF, ddr_wstrb);
         check_val("scrub wlast", beat == len_m1, ddr_wlast);
         // Responder answers after the final beat
         if (beat == len_m1)
            b_pending = 1'b1;
         beat++;
      end
      if (ddr_bvalid)
      begin
         check_val("scrub bready", 1, ddr_bready);
         check_val("scrub beats per burst", len_m1 + 1, beat);
         if (ddr_bresp != 2'b00)
            err_exp = 1'b1;
         resp_count++;
         burst_idx++;
         beat = 0;
         aw_open = 1'b0;
      end
   endtask

   always @(negedge clk)
   begin
      if (pipe_rst_n)
      begin
         ncyc++;
         check_val("bound assertions", 0,
                   {u_dut.u_sva.aw_fail, u_dut.u_sva.w_fail, u_dut.u_sva.done_fail});
         watch_stat();
         watch_scrub();
      end
   end

   // DDR write responder with random stalls
   always @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         ddr_awready <= 1'b0;
         ddr_wready  <= 1'b0;
         ddr_bvalid  <= 1'b0;
      end
      else
      begin
         rng = xorshift32(rng);
         ddr_awready <= rng[0] | rng[1];
         ddr_wready  <= rng[8] | rng[9];
         if (b_pending)
         begin
            ddr_bvalid <= 1'b1;
            ddr_bresp  <= (b_issued == err_burst) ? 2'b10 : 2'b00;
            b_issued++;
            b_pending = 1'b0;
         end
         else
            ddr_bvalid <= 1'b0;
      end
   end

   task run_flr;
      logic prev;
      prev = 1'b0;
      @(posedge clk);
      sh_cl_flr_assert <= 1'b1;
      for (int k = 0; k < 8; k++)
      begin
         @(negedge clk);
         if (k < 2)
            check_val("flr done early", 0, cl_sh_flr_done);
         else if (k == 2)
            check_val("flr done", 1, cl_sh_flr_done);
         else
            check_val("flr single pulse", 0, prev & cl_sh_flr_done);
         prev = cl_sh_flr_done;
      end
      @(posedge clk);
      sh_cl_flr_assert <= 1'b0;
      repeat (4) @(negedge clk);
      check_val("flr done released", 0, cl_sh_flr_done);
   endtask

   //////////////////////////////////////////////////
   // Watchdog and main sequence
   //////////////////////////////////////////////////
   initial
   begin
      int limit;
      wait (cfg_ready);
      limit = n_bursts * (len_m1 + 1 + 20) + n_rows * (STAT_STAGES + 4) + 200;
      repeat (limit) @(posedge clk);
      abort_run("timeout: scrub or status traffic did not finish in time");
   end

   initial
   begin
      pipe_rst_n        = 1'b0;
      scrb_en           = 1'b1;
      sh_cl_flr_assert  = 1'b0;
      sh_ddr_stat_wr    = 1'b0;
      sh_ddr_stat_rd    = 1'b0;
      sh_ddr_stat_addr  = '0;
      sh_ddr_stat_wdata = '0;
      stat_ack_q        = 1'b0;
      stat_rdata_q      = '0;
      stat_int_q        = '0;
      cur_lat           = 0;
      load_patterns();
      cfg_ready = 1'b1;

      repeat (4) @(posedge clk);
      pipe_rst_n <= 1'b1;
      @(negedge clk);
      check_val("outputs after reset", 0,
                {ddr_awvalid, ddr_wvalid, scrb_done, scrb_err, cl_sh_flr_done,
                 stat_wr_q, stat_rd_q, ddr_sh_stat_ack});

      // Back-to-back status rows while the scrub runs
      for (int i = 0; i < n_rows; i++)
         drive_stat_row(i);
      @(posedge clk);
      sh_ddr_stat_wr <= 1'b0;
      sh_ddr_stat_rd <= 1'b0;
      stat_ack_q     <= 1'b0;
      while (req_q.size() != 0 || rsp_q.size() != 0)
         @(negedge clk);

      run_flr();

      while (!scrb_done)
         @(negedge clk);
      repeat (20) @(negedge clk);
      check_val("scrub burst total", n_bursts, resp_count);
      check_val("scrub err final", err_burst >= 0 && err_burst < n_bursts, scrb_err);

      if ({u_dut.u_sva.aw_fail, u_dut.u_sva.w_fail, u_dut.u_sva.done_fail} == 3'b000)
      begin
         $display("TB PASSED");
         $finish;
      end
      else
         abort_run("a bound assertion failed");
   end

endmodule

`default_nettype wire

// File: sim.f
design/cl_scrub_pkg.sv
design/scrub_ctl_if.sv
design/scrub_fsm.sv
design/scrub_addr_counter.sv
design/scrub_wr_port.sv
design/ddr_stat_pipe.sv
design/cl_dram_scrub.sv
tests/cl_dram_scrub_sva.sv
tests/tb_cl_dram_scrub.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cl_dram_scrub
FILELIST = sim.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

lint:
	$(TOOL) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/scrub_patterns.txt
// Columns (hex): op addr data int lat. op bit0 status wr, bit1 status rd, bit2 ack
// op 08 scrub region (addr = max address, data = burst length - 1), 09 SLVERR burst, FF end
08 00001FFF 0000000F 00 00
09 00000000 00000005 00 00
01 00000010 A5A50001 00 08
02 00000024 00000000 00 08
01 00000030 DEADBEEF 00 08
00 00000000 00000000 00 00
04 00000000 12345678 03 08
04 00000000 CAFEF00D 80 08
05 00000044 0BADC0DE 5A 08
02 000000FF 00000000 00 08
06 000000FE 55AA55AA 01 08
00 00000000 00000000 00 00
01 00000001 00000001 00 08
04 00000000 FFFFFFFF FF 08
03 0000007E 13572468 00 08
00 00000000 00000000 00 00
FF 00000000 00000000 00 00
